// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - files:
      - common/isa_pkg.sv
      - common/ooo_pkg.sv
      - common/rob_if.sv
      - rtl/issue/issue_unit.sv
      - rtl/reg_status_file.sv
      - rtl/execute_units.sv
      - rtl/rob/reorder_buffer.sv
      - rtl/commit_unit.sv
      - rtl/core.sv
  - target: test
    files:
      - tests/core_props.sv
      - tests/core_tb.sv

// ==== common/isa_pkg.sv ====
// Instruction word views and operation codes for the reduced RV32 integer subset.
// Only ADD, SUB, SLL, SRL, ADDI and MUL decode; every other word becomes NOP.
`default_nettype none

package isa_pkg;

    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;

    // major opcodes and funct7 patterns
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0]              imm12;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } i_fields_t;

    // the same 32 bits seen as R-type or I-type
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } ins_word_t;

    typedef enum logic [2:0] {ADD, SUB, SLL, SRL, MUL, NOP} alu_op_t;

endpackage

`default_nettype wire

// ==== common/ooo_pkg.sv ====
// Machine sizes and the packets passed around the out-of-order core.
// rob_tag_t is sized from ROB_DEPTH, so a core's rob_depth may not exceed it.
`default_nettype none

package ooo_pkg;

    localparam int ROB_DEPTH = 8;

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    // one result broadcast per cycle
    typedef struct packed {
        logic                      valid;
        rob_tag_t                  tag;
        logic [isa_pkg::XLEN-1:0] value;
    } cdb_packet_t;

    typedef struct packed {
        logic                               writes;
        logic [isa_pkg::REG_ADDR_BITS-1:0] rd;
        logic                               ready;
        logic [isa_pkg::XLEN-1:0]          value;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== common/rob_if.sv ====
// Allocation, operand lookup and credit return between issue, ROB and commit.
`timescale 1ns/100ps
`default_nettype none

interface rob_if;
    import isa_pkg::*;
    import ooo_pkg::*;

    logic                     alloc_valid;
    rob_tag_t                 alloc_tag;
    logic [REG_ADDR_BITS-1:0] alloc_rd;
    logic                     alloc_writes;
    rob_tag_t                 lookup_tag_j;
    rob_tag_t                 lookup_tag_k;
    logic                     lookup_ready_j;
    logic                     lookup_ready_k;
    logic [XLEN-1:0]          lookup_value_j;
    logic [XLEN-1:0]          lookup_value_k;
    // tag of the entry at the head, used to release register status
    rob_tag_t                 head_tag;
    logic                     credit_return;

    modport issue (
        output alloc_valid, alloc_tag, alloc_rd, alloc_writes, lookup_tag_j, lookup_tag_k,
        input  lookup_ready_j, lookup_ready_k, lookup_value_j, lookup_value_k, credit_return
    );
    modport rob (
        input  alloc_valid, alloc_tag, alloc_rd, alloc_writes, lookup_tag_j, lookup_tag_k,
        output lookup_ready_j, lookup_ready_k, lookup_value_j, lookup_value_k, head_tag
    );
    modport commit (
        input  head_tag,
        output credit_return
    );
endinterface

`default_nettype wire

// ==== list.f ====
common/isa_pkg.sv
common/ooo_pkg.sv
common/rob_if.sv
rtl/issue/issue_unit.sv
rtl/reg_status_file.sv
rtl/execute_units.sv
rtl/rob/reorder_buffer.sv
rtl/commit_unit.sv
rtl/core.sv
tests/core_props.sv
tests/core_tb.sv

// ==== rtl/commit_unit.sv ====
// Retires at most one ready head entry per cycle, purely combinational.
`timescale 1ns/100ps
`default_nettype none

module commit_unit (
    input  ooo_pkg::rob_entry_t               head,
    input  logic                              head_valid,
    output logic                              pop,
    rob_if.commit                             rob,
    output ooo_pkg::rob_tag_t                 commit_tag,
    output logic                              reg_write,
    output logic [isa_pkg::REG_ADDR_BITS-1:0] rd,
    output logic [isa_pkg::XLEN-1:0]          write_data,
    output logic                              commit_valid,
    output logic                              commit_writes,
    output logic [isa_pkg::REG_ADDR_BITS-1:0] commit_rd,
    output logic [isa_pkg::XLEN-1:0]          commit_data
);

    assign pop               = head_valid && head.ready;
    // every retired entry hands its slot back to issue
    assign rob.credit_return = pop;

    // register file side
    assign commit_tag = rob.head_tag;
    assign reg_write  = pop && head.writes;
    assign rd         = head.rd;
    assign write_data = head.value;

    // observation port
    assign commit_valid  = pop;
    assign commit_writes = pop && head.writes;
    assign commit_rd     = head.rd;
    assign commit_data   = head.value;

endmodule

`default_nettype wire

// ==== rtl/core.sv ====
// Reduced Tomasulo core: in-order issue, two units, ROB commit in program order.
// rob_depth must be a power of two no larger than ooo_pkg::ROB_DEPTH.
`timescale 1ns/100ps
`default_nettype none

module core #(
    parameter int rob_depth  = ooo_pkg::ROB_DEPTH,
    parameter int mul_cycles = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ins_valid,
    input  logic [31:0]                       ins_word,
    output logic                              stall,
    output logic                              commit_valid,
    output logic                              commit_writes,
    output logic [isa_pkg::REG_ADDR_BITS-1:0] commit_rd,
    output logic [isa_pkg::XLEN-1:0]          commit_data
);
    import isa_pkg::*;
    import ooo_pkg::*;

    //------------------------------------------------------------
    // wires between units
    //------------------------------------------------------------
    rob_if rob_bus ();

    cdb_packet_t              cdb;
    rob_entry_t               head;
    logic                     head_valid;
    logic                     pop;
    // operand reads and rename
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [XLEN-1:0]          reg_data_j;
    logic [XLEN-1:0]          reg_data_k;
    logic                     reg_busy_j;
    logic                     reg_busy_k;
    rob_tag_t                 q_j;
    rob_tag_t                 q_k;
    logic [REG_ADDR_BITS-1:0] issue_rd;
    logic                     issue_writes;
    rob_tag_t                 issue_tag;
    // issue to execute
    logic                     dispatch_valid;
    alu_op_t                  dispatch_op;
    rob_tag_t                 dispatch_tag;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic                     add_busy;
    logic                     mul_busy;
    // commit to register file
    rob_tag_t                 commit_tag;
    logic                     reg_write;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [XLEN-1:0]          write_data;

    //------------------------------------------------------------
    // units
    //------------------------------------------------------------
    issue_unit #(.rob_depth(rob_depth)) issue (
        .clk, .rst_n, .ins_valid, .ins_word(ins_word_t'(ins_word)), .stall,
        .rob(rob_bus.issue), .rs1, .rs2, .reg_data_j, .reg_data_k,
        .reg_busy_j, .reg_busy_k, .q_j, .q_k, .issue_rd, .issue_writes, .issue_tag,
        .dispatch_valid, .dispatch_op, .dispatch_tag, .operand_a, .operand_b,
        .add_busy, .mul_busy
    );

    reg_status_file registers (
        .clk, .rst_n, .rs1, .rs2, .rs1_data(reg_data_j), .rs2_data(reg_data_k),
        .rs1_busy(reg_busy_j), .rs2_busy(reg_busy_k), .q_j, .q_k,
        .issue_rd, .issue_writes, .issue_tag, .rd, .reg_write, .write_data, .commit_tag
    );

    execute_units #(.mul_cycles(mul_cycles)) execute (
        .clk, .rst_n, .dispatch_valid, .dispatch_op, .dispatch_tag,
        .operand_a, .operand_b, .add_busy, .mul_busy, .cdb
    );

    reorder_buffer #(.rob_depth(rob_depth)) rob (
        .clk, .rst_n, .rob(rob_bus.rob), .cdb, .head, .head_valid, .pop
    );

    commit_unit commit (
        .head, .head_valid, .pop, .rob(rob_bus.commit), .commit_tag,
        .reg_write, .rd, .write_data,
        .commit_valid, .commit_writes, .commit_rd, .commit_data
    );

endmodule

`default_nettype wire

// ==== rtl/execute_units.sv ====
// Single-cycle adder/shifter and an iterative shift-add multiplier sharing one CDB.
// The multiplier always wins the bus; the adder holds its result until granted.
`timescale 1ns/100ps
`default_nettype none

module execute_units #(
    parameter int mul_cycles = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dispatch_valid,
    input  isa_pkg::alu_op_t         dispatch_op,
    input  ooo_pkg::rob_tag_t        dispatch_tag,
    input  logic [isa_pkg::XLEN-1:0] operand_a,
    input  logic [isa_pkg::XLEN-1:0] operand_b,
    output logic                     add_busy,
    output logic                     mul_busy,
    output ooo_pkg::cdb_packet_t     cdb
);
    import isa_pkg::*;
    import ooo_pkg::*;

    // multiplier bits examined per cycle so the product covers XLEN bits
    localparam int STEP_BITS = (XLEN + mul_cycles - 1) / mul_cycles;
    localparam int LEFT_BITS = $clog2(mul_cycles + 1);

    logic                 dispatch_add;
    logic                 dispatch_mul;
    logic                 add_valid;
    logic                 add_grant;
    rob_tag_t             add_tag;
    logic [XLEN-1:0]      add_next;
    logic [XLEN-1:0]      add_result;
    logic                 mul_pending;
    logic                 mul_done;
    logic [LEFT_BITS-1:0] mul_left;
    rob_tag_t             mul_tag;
    logic [XLEN-1:0]      mul_a;
    logic [XLEN-1:0]      mul_b;
    logic [XLEN-1:0]      mul_acc;
    logic [XLEN-1:0]      step_a;
    logic [XLEN-1:0]      step_b;
    logic [XLEN-1:0]      step_acc;

    assign dispatch_mul = dispatch_valid && (dispatch_op == MUL);
    assign dispatch_add = dispatch_valid && (dispatch_op != MUL);

    //------------------------------------------------------------
    // adder / shifter
    //------------------------------------------------------------
    always_comb begin
        case (dispatch_op)
            ADD:     add_next = operand_a + operand_b;
            SUB:     add_next = operand_a - operand_b;
            SLL:     add_next = operand_a << operand_b[4:0];
            SRL:     add_next = operand_a >> operand_b[4:0];
            default: add_next = '0;
        endcase
    end

    assign add_grant = add_valid && !mul_done;
    // a granted result frees the unit for a dispatch in the same cycle
    assign add_busy  = add_valid && mul_done;

    //------------------------------------------------------------
    // multiplier, low XLEN bits of the product
    //------------------------------------------------------------
    always_comb begin
        step_a   = dispatch_mul ? operand_a : mul_a;
        step_b   = dispatch_mul ? operand_b : mul_b;
        step_acc = dispatch_mul ? '0 : mul_acc;
        for (int i = 0; i < STEP_BITS; i++) begin
            if (step_b[0]) begin
                step_acc = step_acc + step_a;
            end
            step_a = step_a << 1;
            step_b = step_b >> 1;
        end
    end

    assign mul_done = mul_pending && (mul_left == '0);
    assign mul_busy = mul_pending && !mul_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            add_valid   <= 1'b0;
            mul_pending <= 1'b0;
            mul_left    <= '0;
        end else begin
            if (dispatch_add) begin
                add_valid <= 1'b1;
            end else if (add_grant) begin
                add_valid <= 1'b0;
            end
            if (dispatch_mul) begin
                mul_pending <= 1'b1;
                mul_left    <= LEFT_BITS'(mul_cycles - 1);
            end else begin
                if (mul_done) begin
                    mul_pending <= 1'b0;
                end
                if (mul_left != '0) begin
                    mul_left <= mul_left - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_add) begin
            add_result <= add_next;
            add_tag    <= dispatch_tag;
        end
        if (dispatch_mul || mul_left != '0) begin
            mul_a   <= step_a;
            mul_b   <= step_b;
            mul_acc <= step_acc;
        end
        if (dispatch_mul) begin
            mul_tag <= dispatch_tag;
        end
    end

    //------------------------------------------------------------
    // CDB arbitration
    //------------------------------------------------------------
    always_comb begin
        cdb = '0;
        if (mul_done) begin
            cdb = '{valid: 1'b1, tag: mul_tag, value: mul_acc};
        end else if (add_valid) begin
            cdb = '{valid: 1'b1, tag: add_tag, value: add_result};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue/issue_unit.sv ====
// In-order issue. An instruction waits at the input until both operands exist
// and its unit is free, so nothing downstream ever snoops the CDB.
`timescale 1ns/100ps
`default_nettype none

module issue_unit #(
    parameter int rob_depth = ooo_pkg::ROB_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ins_valid,
    input  isa_pkg::ins_word_t                ins_word,
    output logic                              stall,
    rob_if.issue                              rob,
    output logic [isa_pkg::REG_ADDR_BITS-1:0] rs1,
    output logic [isa_pkg::REG_ADDR_BITS-1:0] rs2,
    input  logic [isa_pkg::XLEN-1:0]          reg_data_j,
    input  logic [isa_pkg::XLEN-1:0]          reg_data_k,
    input  logic                              reg_busy_j,
    input  logic                              reg_busy_k,
    input  ooo_pkg::rob_tag_t                 q_j,
    input  ooo_pkg::rob_tag_t                 q_k,
    output logic [isa_pkg::REG_ADDR_BITS-1:0] issue_rd,
    output logic                              issue_writes,
    output ooo_pkg::rob_tag_t                 issue_tag,
    output logic                              dispatch_valid,
    output isa_pkg::alu_op_t                  dispatch_op,
    output ooo_pkg::rob_tag_t                 dispatch_tag,
    output logic [isa_pkg::XLEN-1:0]          operand_a,
    output logic [isa_pkg::XLEN-1:0]          operand_b,
    input  logic                              add_busy,
    input  logic                              mul_busy
);
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int CREDIT_BITS = $clog2(rob_depth + 1);

    alu_op_t                op;
    logic                   is_r;
    logic                   writes;
    logic                   ready_j;
    logic                   ready_k;
    logic                   unit_busy;
    logic                   accept;
    logic [XLEN-1:0]        imm_se;
    logic [CREDIT_BITS-1:0] credits;
    rob_tag_t               tail;

    //------------------------------------------------------------
    // decode
    //------------------------------------------------------------
    assign is_r = (ins_word.r.opcode == OPC_OP);

    always_comb begin
        op = NOP;
        if (is_r) begin
            case ({ins_word.r.funct7, ins_word.r.funct3})
                {F7_BASE, 3'b000}:   op = ADD;
                {F7_ALT, 3'b000}:    op = SUB;
                {F7_BASE, 3'b001}:   op = SLL;
                {F7_BASE, 3'b101}:   op = SRL;
                {F7_MULDIV, 3'b000}: op = MUL;
                default:             op = NOP;
            endcase
        end else if (ins_word.i.opcode == OPC_OP_IMM && ins_word.i.funct3 == 3'b000) begin
            op = ADD;
        end
    end

    assign imm_se = {{(XLEN - 12){ins_word.i.imm12[11]}}, ins_word.i.imm12};
    // x0 destinations and unknown words still take a ROB entry
    assign writes = (op != NOP) && (ins_word.r.rd != '0);

    //------------------------------------------------------------
    // operands and stall
    //------------------------------------------------------------
    assign rs1              = ins_word.r.rs1;
    assign rs2              = ins_word.r.rs2;
    assign rob.lookup_tag_j = q_j;
    assign rob.lookup_tag_k = q_k;

    // a renamed source is usable once its ROB entry is ready
    assign ready_j   = !reg_busy_j || rob.lookup_ready_j;
    assign ready_k   = !reg_busy_k || rob.lookup_ready_k;
    assign unit_busy = (op == MUL) ? mul_busy : add_busy;

    assign stall = ins_valid && ((credits == '0) || unit_busy ||
                                 (op != NOP && !ready_j) ||
                                 (op != NOP && is_r && !ready_k));
    assign accept = ins_valid && !stall;

    assign operand_a = reg_busy_j ? rob.lookup_value_j : reg_data_j;
    assign operand_b = !is_r ? imm_se : (reg_busy_k ? rob.lookup_value_k : reg_data_k);

    //------------------------------------------------------------
    // rename, allocate and dispatch
    //------------------------------------------------------------
    assign dispatch_valid   = accept;
    assign dispatch_op      = op;
    assign dispatch_tag     = tail;
    assign rob.alloc_valid  = accept;
    assign rob.alloc_tag    = tail;
    assign rob.alloc_rd     = ins_word.r.rd;
    assign rob.alloc_writes = writes;
    assign issue_rd         = ins_word.r.rd;
    assign issue_writes     = accept && writes;
    assign issue_tag        = tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_BITS'(rob_depth);
            tail    <= '0;
        end else begin
            credits <= credits - CREDIT_BITS'(accept) + CREDIT_BITS'(rob.credit_return);
            if (accept) begin
                tail <= (tail == rob_tag_t'(rob_depth - 1)) ? '0 : tail + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_status_file.sv ====
// Architectural registers with a busy flag and producer tag per register.
// x0 reads zero and is never marked busy.
`timescale 1ns/100ps
`default_nettype none

module reg_status_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [isa_pkg::REG_ADDR_BITS-1:0] rs1,
    input  logic [isa_pkg::REG_ADDR_BITS-1:0] rs2,
    output logic [isa_pkg::XLEN-1:0]          rs1_data,
    output logic [isa_pkg::XLEN-1:0]          rs2_data,
    output logic                              rs1_busy,
    output logic                              rs2_busy,
    output ooo_pkg::rob_tag_t                 q_j,
    output ooo_pkg::rob_tag_t                 q_k,
    input  logic [isa_pkg::REG_ADDR_BITS-1:0] issue_rd,
    input  logic                              issue_writes,
    input  ooo_pkg::rob_tag_t                 issue_tag,
    input  logic [isa_pkg::REG_ADDR_BITS-1:0] rd,
    input  logic                              reg_write,
    input  logic [isa_pkg::XLEN-1:0]          write_data,
    input  ooo_pkg::rob_tag_t                 commit_tag
);
    import isa_pkg::*;
    import ooo_pkg::*;

    logic [XLEN-1:0] regs [32];
    logic [31:0]     busy;
    rob_tag_t        tags [32];

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];
    assign q_j      = tags[rs1];
    assign q_k      = tags[rs2];

    // register state starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && rd != '0) begin
            regs[rd] <= write_data;
        end
    end

    // a newer producer keeps the register busy, so clear only on a tag match
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (reg_write && tags[rd] == commit_tag) begin
                busy[rd] <= 1'b0;
            end
            // issue wins over commit on the same register
            if (issue_writes && issue_rd != '0) begin
                busy[issue_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_writes && issue_rd != '0) begin
            tags[issue_rd] <= issue_tag;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rob/reorder_buffer.sv ====
// Circular reorder buffer. Issue picks the slot through its own tail tag, the
// CDB fills value and ready, and entries leave from the head in program order.
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = ooo_pkg::ROB_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst_n,
    rob_if.rob                   rob,
    input  ooo_pkg::cdb_packet_t cdb,
    output ooo_pkg::rob_entry_t  head,
    output logic                 head_valid,
    input  logic                 pop
);
    import ooo_pkg::*;

    localparam int COUNT_BITS = $clog2(rob_depth + 1);

    rob_entry_t            entries [rob_depth];
    rob_tag_t              head_ptr;
    logic [COUNT_BITS-1:0] count;

    //------------------------------------------------------------
    // entry store
    //------------------------------------------------------------
    // alloc and CDB never hit the same slot, one is free and one is in flight
    always_ff @(posedge clk) begin
        if (rob.alloc_valid) begin
            entries[rob.alloc_tag].writes <= rob.alloc_writes;
            entries[rob.alloc_tag].rd     <= rob.alloc_rd;
            entries[rob.alloc_tag].ready  <= 1'b0;
        end
        if (cdb.valid) begin
            entries[cdb.tag].ready <= 1'b1;
            entries[cdb.tag].value <= cdb.value;
        end
    end

    assign rob.lookup_ready_j = entries[rob.lookup_tag_j].ready;
    assign rob.lookup_ready_k = entries[rob.lookup_tag_k].ready;
    assign rob.lookup_value_j = entries[rob.lookup_tag_j].value;
    assign rob.lookup_value_k = entries[rob.lookup_tag_k].value;

    //------------------------------------------------------------
    // head pointer and occupancy
    //------------------------------------------------------------
    assign head         = entries[head_ptr];
    assign head_valid   = (count != '0);
    assign rob.head_tag = head_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            count    <= '0;
        end else begin
            count <= count + COUNT_BITS'(rob.alloc_valid) - COUNT_BITS'(pop);
            if (pop) begin
                head_ptr <= (head_ptr == rob_tag_t'(rob_depth - 1)) ? '0 : head_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/core_props.sv ====
// Concurrent checks bound into the core.
// Reads the issue credit counter and the ROB occupancy by hierarchy.
`timescale 1ns/100ps
`default_nettype none

module core_props #(
    parameter int rob_depth = ooo_pkg::ROB_DEPTH
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             alloc_valid,
    input logic                             commit_valid,
    input ooo_pkg::rob_tag_t                head_tag,
    input ooo_pkg::cdb_packet_t             cdb,
    input logic [$clog2(rob_depth + 1)-1:0] credits,
    input logic [$clog2(rob_depth + 1)-1:0] rob_count
);

    credits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= rob_depth)
        else $error("issue credits exceed rob_depth");

    // the head's ready bit lags its CDB packet by one cycle
    commit_after_head_result: assert property (@(posedge clk) disable iff (!rst_n)
        (cdb.valid && cdb.tag == head_tag) |-> !commit_valid)
        else $error("ROB head retired before its result was written");

    no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_valid |-> (rob_count < rob_depth))
        else $error("ROB allocation while every entry is occupied");

endmodule

bind core core_props #(.rob_depth(rob_depth)) props (
    .clk, .rst_n, .alloc_valid(rob_bus.alloc_valid), .commit_valid,
    .head_tag(rob_bus.head_tag), .cdb, .credits(issue.credits), .rob_count(rob.count)
);

`default_nettype wire

// ==== tests/core_tb.sv ====
// Drives the core from tests/core_testdata.txt and checks every commit in program order.
// Run from the project root so the data file path resolves; at most 64 instructions.
`timescale 1ns/100ps
`default_nettype none

module core_tb;
    import isa_pkg::*;

    localparam int MAX_INS      = 64;
    localparam int RAW_WORDS    = 4 * MAX_INS;
    localparam int STALL_LIMIT  = 200;
    localparam int COMMIT_LIMIT = 400;
    localparam int ROB_ENTRIES  = 8;

    logic                     clk;
    logic                     rst_n;
    logic                     ins_valid;
    logic [31:0]              ins_word;
    logic                     stall;
    logic                     commit_valid;
    logic                     commit_writes;
    logic [REG_ADDR_BITS-1:0] commit_rd;
    logic [XLEN-1:0]          commit_data;

    // four hex words per instruction: word, writes, rd, data
    logic [31:0] raw [RAW_WORDS];
    logic [31:0] ins_mem [MAX_INS];
    logic [37:0] exp_rec [MAX_INS];
    int          ins_count;
    int          commits;
    int          accepted;
    int          full_stalls;
    int          value_errors;
    int          other_errors;
    logic        timed_out;
    logic [15:0] lfsr;

    core #(.rob_depth(ROB_ENTRIES)) UUT (
        .clk, .rst_n, .ins_valid, .ins_word, .stall,
        .commit_valid, .commit_writes, .commit_rd, .commit_data
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    //------------------------------------------------------------
    // helpers
    //------------------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_gap(output int gap);
        lfsr = lfsr_next(lfsr);
        gap  = int'(lfsr[0]);
    endtask

    task automatic load_testdata();
        int base;
        $readmemh("tests/core_testdata.txt", raw);
        ins_count = 0;
        while (ins_count < MAX_INS && !$isunknown(raw[4 * ins_count])) begin
            base               = 4 * ins_count;
            ins_mem[ins_count] = raw[base];
            exp_rec[ins_count] = {raw[base + 1][0], raw[base + 2][4:0], raw[base + 3]};
            ins_count++;
        end
        if (ins_count == 0) begin
            $display("no instructions found in the test data");
            other_errors++;
        end
    endtask

    // a non-writing commit may also show up as a write to x0
    task automatic check_commit(
        input int                       index,
        input logic                     writes,
        input logic [REG_ADDR_BITS-1:0] rd,
        input logic [XLEN-1:0]          data,
        input logic                     exp_writes,
        input logic [REG_ADDR_BITS-1:0] exp_rd,
        input logic [XLEN-1:0]          exp_data
    );
        if (!exp_writes) begin
            if (writes !== 1'b0 && rd !== '0) begin
                $display("Error at %0t: commit %0d wrote x%0d, expected no write",
                         $time, index, rd);
                value_errors++;
            end
        end else if (writes !== 1'b1 || rd !== exp_rd || data !== exp_data) begin
            $display("Error at %0t: commit %0d gave writes=%b x%0d=%h, expected x%0d=%h",
                     $time, index, writes, rd, data, exp_rd, exp_data);
            value_errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            value_errors++;
        end
    endtask

    task automatic wait_accept(input int index);
        int waited;
        waited = 0;
        @(negedge clk);
        while (stall !== 1'b0 && waited < STALL_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (stall !== 1'b0) begin
            $display("stall never dropped for instruction %0d", index);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            // the instruction is taken on this edge
            @(posedge clk);
        end
    endtask

    task automatic wait_commits();
        int waited;
        waited = 0;
        while (commits < ins_count && waited < COMMIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (commits < ins_count) begin
            $display("commits stopped after %0d of %0d instructions", commits, ins_count);
            other_errors++;
        end
    endtask

    //------------------------------------------------------------
    // commit monitor
    //------------------------------------------------------------
    // accept and commit seen here take effect on the next rising edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && ins_valid === 1'b1) begin
            if (stall === 1'b0) begin
                accepted++;
            end else if (accepted - commits == ROB_ENTRIES) begin
                full_stalls++;
            end
        end
        if (rst_n === 1'b1 && commit_valid === 1'b1) begin
            if (commits < ins_count) begin
                check_commit(commits, commit_writes, commit_rd, commit_data,
                             exp_rec[commits][37], exp_rec[commits][36:32],
                             exp_rec[commits][31:0]);
            end else begin
                $display("an extra commit appeared after the last instruction at %0t", $time);
                other_errors++;
            end
            commits++;
        end
    end

    //------------------------------------------------------------
    // stimulus
    //------------------------------------------------------------
    initial begin
        int gap;
        rst_n        = 1'b0;
        ins_valid    = 1'b0;
        ins_word     = '0;
        commits      = 0;
        accepted     = 0;
        full_stalls  = 0;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        lfsr         = 16'd24865;
        load_testdata();

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (stall !== 1'b0 || commit_valid !== 1'b0) begin
            $display("stall or commit_valid was not low after reset");
            other_errors++;
        end

        @(posedge clk);
        for (int i = 0; i < ins_count && !timed_out; i++) begin
            random_gap(gap);
            if (gap != 0) begin
                ins_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            ins_valid <= 1'b1;
            ins_word  <= ins_mem[i];
            wait_accept(i);
        end
        ins_valid <= 1'b0;

        if (!timed_out) begin
            wait_commits();
        end
        // a few idle cycles so a stray extra commit is still seen
        repeat (5) @(negedge clk);
        check_count("commit count", commits, ins_count);
        if (full_stalls == 0) begin
            $display("stall never rose while the ROB filled behind the multiply");
            other_errors++;
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/core_testdata.txt ====
// columns, all hex: instruction word, expected writes, expected rd, expected data
// one line per instruction in program order; data is ignored when writes is 0
00500093 1 01 00000005
FFD08113 1 02 00000002
002081B3 1 03 00000007
40310233 1 04 FFFFFFFB
001192B3 1 05 000000E0
00225333 1 06 3FFFFFFE
00918013 0 00 00000000
005003B3 1 07 000000E0
00000F8B 0 1F 00000000
0020C433 0 08 00000000
02308433 1 08 00000023
00100493 1 09 00000001
00200513 1 0A 00000002
00300593 1 0B 00000003
00400613 1 0C 00000004
00500693 1 0D 00000005
00600713 1 0E 00000006
00700793 1 0F 00000007
00800813 1 10 00000008
00900893 1 11 00000009
02840933 1 12 000004C9
011909B3 1 13 000004D2
40100A33 1 14 FFFFFFFB
